//--- logic/ps2_keyboard_pkg.sv
package ps2_keyboard_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	typedef logic [7:0] ps2_code_t;    // one byte off the PS/2 line
	typedef logic [6:0] amiga_code_t;  // Amiga raw key code

	// key event as seen by the Amiga side
	typedef struct packed
	{
		logic        released;  // 1 = key up
		amiga_code_t code;
	} amiga_key_t;

	// one result of the scan code table
	typedef struct packed
	{
		logic        mapped;             // key exists on the Amiga
		logic        is_ctrl;
		logic        is_left_alt;
		logic        is_right_alt;
		logic        is_caps;
		logic        is_prefix_ext;      // E0
		logic        is_prefix_release;  // F0
		logic        is_prefix_ack;      // FA leaves prefix flags alone
		amiga_code_t code;
	} keymap_entry_t;

	// ----------------------------------------
	// controller
	// ----------------------------------------
	typedef enum logic [0:0]
	{
		ST_WAIT_KEY = 1'b0,
		ST_HOLD     = 1'b1
	} ctrl_state_t;

	localparam int FRAME_BITS = 11;  // start, 8 data, parity, stop

	// clk cycles the keyboard clock stays pulled low without an acknowledge
	localparam int HOLD_TIMEOUT_CYCLES = 4096;
	localparam int HOLD_TIMER_WIDTH = $clog2(HOLD_TIMEOUT_CYCLES);

	typedef logic [HOLD_TIMER_WIDTH-1:0] hold_timer_t;

	localparam hold_timer_t HOLD_TIMER_LAST = hold_timer_t'(HOLD_TIMEOUT_CYCLES - 1);

	// ----------------------------------------
	// scan code set 2 prefix bytes
	// ----------------------------------------
	localparam ps2_code_t PS2_EXTENDED = 8'he0;
	localparam ps2_code_t PS2_RELEASE  = 8'hf0;
	localparam ps2_code_t PS2_ACK      = 8'hfa;

endpackage

//--- logic/ps2_receiver.sv
`timescale 1ns/1ns

module ps2_receiver
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        ps2_clk,
	input  logic                        ps2_data,
	output logic                        byte_valid,
	output ps2_keyboard_pkg::ps2_code_t byte_data
);

logic [2:0] clk_sync;   // [1:0] synchronizer, [2] previous sample
logic [1:0] data_sync;
logic       clk_fall;

// bit 0 drops to zero once the start bit arrives there
logic [ps2_keyboard_pkg::FRAME_BITS-1:0] frame;

// ----------------------------------------
// input synchronization
// ----------------------------------------
always_ff @(posedge clk)
begin
	if (reset)
	begin
		clk_sync <= '1;  // idle lines are high
		data_sync <= '1;
	end
	else
	begin
		clk_sync <= {clk_sync[1:0], ps2_clk};
		data_sync <= {data_sync[0], ps2_data};
	end
end

assign clk_fall = clk_sync[2] & ~clk_sync[1];

// ----------------------------------------
// frame shifter
// ----------------------------------------
always_ff @(posedge clk)
begin
	if (reset || byte_valid)
		frame <= '1;  // preset for next frame
	else if (clk_fall)
		frame <= {data_sync[1], frame[ps2_keyboard_pkg::FRAME_BITS-1:1]};
end

// start bit at the end means all 11 bits are in
assign byte_valid = ~frame[0];
assign byte_data = frame[8:1];

endmodule

//--- logic/scancode_map.sv
`timescale 1ns/1ns

module scancode_map
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            byte_valid,
	input  ps2_keyboard_pkg::ps2_code_t     byte_data,
	output logic                            map_valid,
	output ps2_keyboard_pkg::keymap_entry_t map_entry,
	output ps2_keyboard_pkg::amiga_key_t    map_key
);

logic                            entry_valid;  // byte_valid delayed by the table register
ps2_keyboard_pkg::keymap_entry_t entry;
logic                            extended;     // E0 seen
logic                            release_seen; // F0 seen

// plain key with an Amiga code
function automatic ps2_keyboard_pkg::keymap_entry_t key_entry
(
	input ps2_keyboard_pkg::amiga_code_t code
);
	ps2_keyboard_pkg::keymap_entry_t e;
	e = '0;
	e.mapped = 1'b1;
	e.code = code;
	return e;
endfunction

// ----------------------------------------
// scan code set 2 table
// ----------------------------------------
function automatic ps2_keyboard_pkg::keymap_entry_t lookup
(
	input logic                        ext,
	input ps2_keyboard_pkg::ps2_code_t code
);
	ps2_keyboard_pkg::keymap_entry_t e;
	e = '0;
	// prefixes decode the same with or without E0 in front
	if (code == ps2_keyboard_pkg::PS2_EXTENDED)
		e.is_prefix_ext = 1'b1;
	else if (code == ps2_keyboard_pkg::PS2_RELEASE)
		e.is_prefix_release = 1'b1;
	else if (code == ps2_keyboard_pkg::PS2_ACK)
		e.is_prefix_ack = 1'b1;
	else
	begin
		case ({ext, code})
			9'h01c: e = key_entry(7'h20);  // a
			9'h032: e = key_entry(7'h35);  // b
			9'h021: e = key_entry(7'h33);  // c
			9'h023: e = key_entry(7'h22);  // d
			9'h024: e = key_entry(7'h12);  // e
			9'h02b: e = key_entry(7'h23);  // f
			9'h034: e = key_entry(7'h24);  // g
			9'h033: e = key_entry(7'h25);  // h
			9'h043: e = key_entry(7'h17);  // i
			9'h03b: e = key_entry(7'h26);  // j
			9'h042: e = key_entry(7'h27);  // k
			9'h04b: e = key_entry(7'h28);  // l
			9'h03a: e = key_entry(7'h37);  // m
			9'h031: e = key_entry(7'h36);  // n
			9'h044: e = key_entry(7'h18);  // o
			9'h04d: e = key_entry(7'h19);  // p
			9'h015: e = key_entry(7'h10);  // q
			9'h02d: e = key_entry(7'h13);  // r
			9'h01b: e = key_entry(7'h21);  // s
			9'h02c: e = key_entry(7'h14);  // t
			9'h03c: e = key_entry(7'h16);  // u
			9'h02a: e = key_entry(7'h34);  // v
			9'h01d: e = key_entry(7'h11);  // w
			9'h022: e = key_entry(7'h32);  // x
			9'h035: e = key_entry(7'h15);  // y
			9'h01a: e = key_entry(7'h31);  // z
			9'h016: e = key_entry(7'h01);  // 1
			9'h01e: e = key_entry(7'h02);  // 2
			9'h026: e = key_entry(7'h03);  // 3
			9'h025: e = key_entry(7'h04);  // 4
			9'h02e: e = key_entry(7'h05);  // 5
			9'h036: e = key_entry(7'h06);  // 6
			9'h03d: e = key_entry(7'h07);  // 7
			9'h03e: e = key_entry(7'h08);  // 8
			9'h046: e = key_entry(7'h09);  // 9
			9'h045: e = key_entry(7'h0a);  // 0
			9'h029: e = key_entry(7'h40);  // space
			9'h05a: e = key_entry(7'h44);  // enter
			9'h066: e = key_entry(7'h41);  // backspace
			9'h076: e = key_entry(7'h45);  // escape
			9'h012: e = key_entry(7'h60);  // left shift
			9'h059: e = key_entry(7'h61);  // right shift
			9'h014:
			begin
				e = key_entry(7'h63);
				e.is_ctrl = 1'b1;
			end
			9'h011:
			begin
				e = key_entry(7'h64);
				e.is_left_alt = 1'b1;
			end
			9'h058:
			begin
				e = key_entry(7'h62);
				e.is_caps = 1'b1;
			end
			// E0 prefixed keys
			9'h111:
			begin
				e = key_entry(7'h65);
				e.is_right_alt = 1'b1;
			end
			9'h11f: e = key_entry(7'h66);  // left gui to left amiga
			9'h127: e = key_entry(7'h67);  // right gui to right amiga
			9'h16b: e = key_entry(7'h4f);  // arrow left
			9'h172: e = key_entry(7'h4d);  // arrow down
			9'h174: e = key_entry(7'h4e);  // arrow right
			9'h175: e = key_entry(7'h4c);  // arrow up
			default: e = '0;
		endcase
	end
	return e;
endfunction

// registered table lookup
always_ff @(posedge clk)
begin
	if (byte_valid)
		entry <= lookup(extended, byte_data);
end

always_ff @(posedge clk)
begin
	if (reset)
		entry_valid <= 1'b0;
	else
		entry_valid <= byte_valid;
end

// ----------------------------------------
// prefix tracking
// ----------------------------------------
always_ff @(posedge clk)
begin
	if (reset)
	begin
		extended <= 1'b0;
		release_seen <= 1'b0;
	end
	else if (entry_valid)
	begin
		if (entry.is_prefix_ext)
			extended <= 1'b1;
		else if (entry.is_prefix_release)
			release_seen <= 1'b1;
		else if (!entry.is_prefix_ack)
		begin
			extended <= 1'b0;  // key byte consumed both flags
			release_seen <= 1'b0;
		end
	end
end

assign map_valid = entry_valid & entry.mapped;
assign map_entry = entry;
assign map_key = {release_seen, entry.code};

endmodule

//--- logic/key_event_filter.sv
`timescale 1ns/1ns

module key_event_filter
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            map_valid,
	input  ps2_keyboard_pkg::keymap_entry_t map_entry,
	input  ps2_keyboard_pkg::amiga_key_t    map_key,
	output logic                            key_strobe,
	output ps2_keyboard_pkg::amiga_key_t    key,
	output logic                            kbd_reset
);

ps2_keyboard_pkg::amiga_key_t last_key;  // last key pressed or its release
logic key_equal;
logic duplicate;   // typematic repeat or repeated release
logic caps_lock;
logic ctrl_up;
logic left_alt_up;
logic right_alt_up;

// ----------------------------------------
// typematic filter
// ----------------------------------------
assign key_equal = last_key.code == map_key.code;
assign duplicate = key_equal && (last_key.released == map_key.released);

always_ff @(posedge clk)
begin
	if (reset)
		last_key <= '0;
	else if (map_valid && !map_key.released)
		last_key <= map_key;
	else if (map_valid && map_key.released && key_equal)
		last_key <= map_key;  // held key let go
end

// amiga caps lock latches in the keyboard, so emulate that here
always_ff @(posedge clk)
begin
	if (reset)
		caps_lock <= 1'b0;
	else if (map_valid && !map_key.released && map_entry.is_caps && !duplicate)
		caps_lock <= ~caps_lock;
end

// caps events hidden while caps lock is on
assign key_strobe = map_valid && !(caps_lock && map_entry.is_caps) && !duplicate;
assign key = map_key;

// ----------------------------------------
// ctrl-alt-alt reset detector
// ----------------------------------------
always_ff @(posedge clk)
begin
	if (reset)
	begin
		ctrl_up <= 1'b1;
		left_alt_up <= 1'b1;
		right_alt_up <= 1'b1;
	end
	else if (map_valid)
	begin
		if (map_entry.is_ctrl)
			ctrl_up <= map_key.released;
		if (map_entry.is_left_alt)
			left_alt_up <= map_key.released;
		if (map_entry.is_right_alt)
			right_alt_up <= map_key.released;
	end
end

assign kbd_reset = ~(ctrl_up | left_alt_up | right_alt_up);  // all three down

endmodule

//--- logic/key_controller.sv
`timescale 1ns/1ns

module key_controller
(
	input  logic clk,
	input  logic reset,
	input  logic key_strobe,
	input  logic key_ack,
	output logic ps2_clk_hold
);

ps2_keyboard_pkg::ctrl_state_t state;
ps2_keyboard_pkg::hold_timer_t hold_timer;  // cycles spent in ST_HOLD

// ----------------------------------------
// hold-off state machine
// ----------------------------------------
always_ff @(posedge clk)
begin
	if (reset)
	begin
		state <= ps2_keyboard_pkg::ST_WAIT_KEY;
		hold_timer <= '0;
	end
	else
	begin
		unique case (state)
			ps2_keyboard_pkg::ST_WAIT_KEY:
			begin
				hold_timer <= '0;
				if (key_strobe)
					state <= ps2_keyboard_pkg::ST_HOLD;
			end
			ps2_keyboard_pkg::ST_HOLD:
			begin
				hold_timer <= hold_timer + 1'b1;
				// give up on the consumer after the timeout
				if (key_ack || hold_timer == ps2_keyboard_pkg::HOLD_TIMER_LAST)
					state <= ps2_keyboard_pkg::ST_WAIT_KEY;
			end
			default:
			begin
				state <= ps2_keyboard_pkg::ST_WAIT_KEY;
			end
		endcase
	end
end

// keyboard stalls while its clock is pulled low
assign ps2_clk_hold = state == ps2_keyboard_pkg::ST_HOLD;

endmodule

//--- logic/ps2_keyboard.sv
`timescale 1ns/1ns

module ps2_keyboard
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         ps2_clk,       // raw keyboard clock
	input  logic                         ps2_data,      // raw keyboard data
	input  logic                         key_ack,
	output logic                         key_strobe,
	output ps2_keyboard_pkg::amiga_key_t key,
	output logic                         ps2_clk_hold,  // pull keyboard clock low
	output logic                         kbd_reset
);

logic                            byte_valid;
ps2_keyboard_pkg::ps2_code_t     byte_data;
logic                            map_valid;
ps2_keyboard_pkg::keymap_entry_t map_entry;
ps2_keyboard_pkg::amiga_key_t    map_key;

// ----------------------------------------
// receive path
// ----------------------------------------
ps2_receiver i_ps2_receiver
(
	.clk        (clk),
	.reset      (reset),
	.ps2_clk    (ps2_clk),
	.ps2_data   (ps2_data),
	.byte_valid (byte_valid),
	.byte_data  (byte_data)
);

scancode_map i_scancode_map
(
	.clk        (clk),
	.reset      (reset),
	.byte_valid (byte_valid),
	.byte_data  (byte_data),
	.map_valid  (map_valid),
	.map_entry  (map_entry),
	.map_key    (map_key)
);

// repeat, caps lock and reset handling
key_event_filter i_key_event_filter
(
	.clk        (clk),
	.reset      (reset),
	.map_valid  (map_valid),
	.map_entry  (map_entry),
	.map_key    (map_key),
	.key_strobe (key_strobe),
	.key        (key),
	.kbd_reset  (kbd_reset)
);

// ----------------------------------------
// handshake and keyboard stall
// ----------------------------------------
key_controller i_key_controller
(
	.clk          (clk),
	.reset        (reset),
	.key_strobe   (key_strobe),
	.key_ack      (key_ack),
	.ps2_clk_hold (ps2_clk_hold)
);

endmodule

//--- verification/ps2_keyboard_checker.sv
`timescale 1ns/1ns

module ps2_keyboard_checker
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         key_strobe,
	input  ps2_keyboard_pkg::amiga_key_t key,
	input  logic                         ps2_clk_hold,
	input  logic                         key_ack,
	input  logic                         kbd_reset,
	input  int                           cycle,
	input  logic                         exp_valid,   // push one expected event
	input  ps2_keyboard_pkg::amiga_key_t exp_key,
	input  logic                         exp_reset,   // kbd_reset level after the event
	input  int                           exp_cycle,   // cycle the strobe is due in
	input  logic                         test_end,
	input  int                           test_id,
	input  logic                         run_done,
	output int                           errors
);

typedef struct packed
{
	logic                         kbd_reset;
	ps2_keyboard_pkg::amiga_key_t key;
	int                           cycle;
} expect_t;

expect_t pending[$];
expect_t head;
logic    check_reset;   // compare kbd_reset one cycle after a strobe
logic    want_reset;
logic    prev_strobe;
logic    prev_ack;
logic    prev_hold;
int      hold_count;
int      events;
int      test_base;     // error count when the current test began
int      tests;

task automatic report(input string msg);
	$display("CHECK FAILED at %0t: %s", $time, msg);
	errors++;
endtask

initial
begin
	errors = 0;
	events = 0;
	test_base = 0;
	tests = 0;
	check_reset = 1'b0;
end

// outputs settle after the rising edge, so look at them on the falling one
always @(negedge clk)
begin
	if (reset)
	begin
		prev_strobe = 1'b0;
		prev_ack = 1'b0;
		prev_hold = 1'b0;
		hold_count = 0;
	end
	else
	begin
		if (exp_valid)
			pending.push_back({exp_reset, exp_key, exp_cycle});
		if (check_reset && kbd_reset !== want_reset)
			report($sformatf("kbd_reset is %b, expected %b", kbd_reset, want_reset));
		check_reset = 1'b0;

		// ----------------------------------------
		// key events
		// ----------------------------------------
		if (key_strobe)
		begin
			if (ps2_clk_hold)
				report("key_strobe while the keyboard clock is held");
			if (pending.size() == 0)
			begin
				$display("An unexpected key event %h came out at %0t.", key, $time);
				errors++;
			end
			else
			begin
				head = pending.pop_front();
				if (key !== head.key)
					report($sformatf("key %h, expected %h", key, head.key));
				if (cycle != head.cycle)
					report($sformatf("strobe in cycle %0d, expected %0d", cycle, head.cycle));
				check_reset = 1'b1;
				want_reset = head.kbd_reset;
				events++;
			end
		end

		// ----------------------------------------
		// keyboard clock hold
		// ----------------------------------------
		if (prev_strobe && !ps2_clk_hold)
			report("ps2_clk_hold did not rise after key_strobe");
		if (prev_hold && !ps2_clk_hold && !prev_ack
			&& hold_count < ps2_keyboard_pkg::HOLD_TIMEOUT_CYCLES)
			report($sformatf("hold dropped after %0d cycles without key_ack", hold_count));
		if (prev_ack && ps2_clk_hold)
			report("ps2_clk_hold still high in the cycle after key_ack");
		if (ps2_clk_hold && hold_count == ps2_keyboard_pkg::HOLD_TIMEOUT_CYCLES + 2)
			report("ps2_clk_hold stuck past the timeout");
		hold_count = ps2_clk_hold ? hold_count + 1 : 0;
		prev_strobe = key_strobe;
		prev_ack = key_ack;
		prev_hold = ps2_clk_hold;

		if (test_end)
		begin
			if (pending.size() != 0)
			begin
				$display("Test %0d ended with %0d expected key events that never came.",
					test_id, pending.size());
				errors += pending.size();
				pending.delete();
			end
			$display("test %0d done: %0d errors", test_id, errors - test_base);
			test_base = errors;
			tests++;
		end
		if (run_done)
			$display("tests %0d, events %0d, errors %0d", tests, events, errors);
	end
end

endmodule

//--- verification/ps2_keyboard_tb.sv
`timescale 1ns/1ns

module ps2_keyboard_tb;

localparam int KEY_COUNT   = 14;
localparam int KEY_CTRL    = 5;
localparam int KEY_LALT    = 6;
localparam int KEY_CAPS    = 7;
localparam int KEY_RALT    = 8;
localparam int BYTE_CYCLES = 11 * 32 + 16 + 24;  // frame, idle gap, ack wait
localparam int MAX_BYTES   = 900;
localparam int CYCLE_LIMIT = MAX_BYTES * BYTE_CYCLES
	+ 2 * ps2_keyboard_pkg::HOLD_TIMEOUT_CYCLES + 2000;

logic clk;
logic reset;
logic ps2_clk;
logic ps2_data;
logic key_ack;
logic key_strobe;
logic ps2_clk_hold;
logic kbd_reset;
ps2_keyboard_pkg::amiga_key_t key;

int                           cycle;
logic                         exp_valid;
ps2_keyboard_pkg::amiga_key_t exp_key;
logic                         exp_reset;
int                           exp_cycle;
logic                         test_end;
int                           test_id;
logic                         run_done;
int                           errors;
logic                         withhold;    // skip the next key_ack
logic [31:0]                  rng_state;

// {E0, scan code} per key
// Amiga code with bit 7 set for keys the table lacks
logic [8:0] key_scan [KEY_COUNT] = '{9'h01c, 9'h01b, 9'h029, 9'h05a, 9'h012, 9'h014,
	9'h011, 9'h058, 9'h111, 9'h11f, 9'h175, 9'h16b, 9'h005, 9'h15a};
logic [7:0] key_code [KEY_COUNT] = '{8'h20, 8'h21, 8'h40, 8'h44, 8'h60, 8'h63,
	8'h64, 8'h62, 8'h65, 8'h66, 8'h4c, 8'h4f, 8'h80, 8'h80};

// reference model state
ps2_keyboard_pkg::amiga_key_t last_key;
logic caps_on;
logic ctrl_dn;
logic lalt_dn;
logic ralt_dn;

ps2_keyboard i_ps2_keyboard
(
	.clk          (clk),
	.reset        (reset),
	.ps2_clk      (ps2_clk),
	.ps2_data     (ps2_data),
	.key_ack      (key_ack),
	.key_strobe   (key_strobe),
	.key          (key),
	.ps2_clk_hold (ps2_clk_hold),
	.kbd_reset    (kbd_reset)
);

ps2_keyboard_checker i_checker
(
	.clk          (clk),
	.reset        (reset),
	.key_strobe   (key_strobe),
	.key          (key),
	.ps2_clk_hold (ps2_clk_hold),
	.key_ack      (key_ack),
	.kbd_reset    (kbd_reset),
	.cycle        (cycle),
	.exp_valid    (exp_valid),
	.exp_key      (exp_key),
	.exp_reset    (exp_reset),
	.exp_cycle    (exp_cycle),
	.test_end     (test_end),
	.test_id      (test_id),
	.run_done     (run_done),
	.errors       (errors)
);

function logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

task automatic tick();
	@(posedge clk);
	#1;
endtask

// ----------------------------------------
// keyboard model
// ----------------------------------------
task automatic send_byte(input logic [7:0] b, input logic push,
	input ps2_keyboard_pkg::amiga_key_t k, input logic rst);
	logic [10:0] bits;
	bits = {1'b1, ~^b, b, 1'b0};  // stop, odd parity, data, start
	while (ps2_clk_hold)
		tick();
	for (int i = 0; i < 11; i++)
	begin
		ps2_data = bits[i];
		repeat (16) tick();
		ps2_clk = 1'b0;
		if (i == 10 && push)
		begin
			exp_valid = 1'b1;
			exp_key = k;
			exp_reset = rst;
			exp_cycle = cycle + 4;  // sync, shift, table
		end
		tick();
		exp_valid = 1'b0;
		repeat (15) tick();
		ps2_clk = 1'b1;
	end
	repeat (16) tick();
endtask

// one key make or break with its expected result
task automatic send_key(input int idx, input logic rel);
	ps2_keyboard_pkg::amiga_key_t k;
	logic dup;
	logic is_caps;
	logic strobe;
	k = {rel, key_code[idx][6:0]};
	strobe = 1'b0;
	if (!key_code[idx][7])
	begin
		dup = k == last_key;
		is_caps = idx == KEY_CAPS;
		strobe = !dup && !(caps_on && is_caps);
		if (!rel || k.code == last_key.code)
			last_key = k;
		if (!rel && is_caps && !dup)
			caps_on = ~caps_on;
		if (idx == KEY_CTRL)
			ctrl_dn = !rel;
		if (idx == KEY_LALT)
			lalt_dn = !rel;
		if (idx == KEY_RALT)
			ralt_dn = !rel;
	end
	if (key_scan[idx][8])
		send_byte(ps2_keyboard_pkg::PS2_EXTENDED, 1'b0, k, 1'b0);
	if (rel)
		send_byte(ps2_keyboard_pkg::PS2_RELEASE, 1'b0, k, 1'b0);
	send_byte(key_scan[idx][7:0], strobe, k, ctrl_dn && lalt_dn && ralt_dn);
endtask

task automatic finish_test(input int id);
	while (ps2_clk_hold)
		tick();
	repeat (40) tick();
	test_id = id;
	test_end = 1'b1;
	tick();
	test_end = 1'b0;
endtask

initial
begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

// run limit
always @(posedge clk)
begin
	cycle <= cycle + 1;
	if (cycle == CYCLE_LIMIT)
	begin
		$display("The run hit its cycle limit before all tests finished.");
		$display("Verification failed");
		$finish;
	end
end

// consumer with a random acknowledge delay
always
begin : ack_driver
	int delay;
	@(negedge clk);
	if (key_strobe)
	begin
		delay = int'(next_rand() % 32'd21);
		if (withhold)
			withhold = 1'b0;
		else
		begin
			repeat (delay) @(posedge clk);
			@(posedge clk);
			#1 key_ack = 1'b1;
			@(posedge clk);
			#1 key_ack = 1'b0;
		end
	end
end

initial
begin
	logic [31:0] r;
	int idx;
	int reps;
	rng_state = 32'h8ca3_a097;
	reset = 1'b1;
	ps2_clk = 1'b1;
	ps2_data = 1'b1;
	key_ack = 1'b0;
	exp_valid = 1'b0;
	exp_key = '0;
	exp_reset = 1'b0;
	exp_cycle = 0;
	test_end = 1'b0;
	test_id = 0;
	run_done = 1'b0;
	withhold = 1'b0;
	last_key = '0;
	caps_on = 1'b0;
	ctrl_dn = 1'b0;
	lalt_dn = 1'b0;
	ralt_dn = 1'b0;
	repeat (5) tick();
	reset = 1'b0;

	// make and break, extended keys, unmapped codes and FA
	send_key(0, 1'b0);
	send_key(0, 1'b1);
	send_key(10, 1'b0);
	send_key(10, 1'b1);
	send_byte(ps2_keyboard_pkg::PS2_ACK, 1'b0, '0, 1'b0);
	send_key(12, 1'b0);
	send_key(13, 1'b1);
	finish_test(0);

	// typematic repeats
	for (int i = 0; i < 3; i++)
		send_key(1, 1'b0);
	send_key(0, 1'b0);
	send_key(1, 1'b0);
	send_key(1, 1'b1);
	send_key(0, 1'b1);
	finish_test(1);

	// caps lock twice round
	for (int i = 0; i < 4; i++)
		send_key(KEY_CAPS, i[0]);
	finish_test(2);

	// ctrl, left alt, right alt
	send_key(KEY_CTRL, 1'b0);
	send_key(KEY_LALT, 1'b0);
	send_key(KEY_RALT, 1'b0);
	send_key(KEY_RALT, 1'b1);
	send_key(KEY_RALT, 1'b0);
	send_key(KEY_CTRL, 1'b1);
	send_key(KEY_LALT, 1'b1);
	send_key(KEY_RALT, 1'b1);
	finish_test(3);

	// no acknowledge for the first event
	withhold = 1'b1;
	send_key(2, 1'b0);
	send_key(3, 1'b0);
	send_key(2, 1'b1);
	send_key(3, 1'b1);
	finish_test(4);

	for (int i = 0; i < 80; i++)
	begin
		r = next_rand();
		idx = int'(r[15:8] % 8'd14);
		reps = int'(r[4:3] % 2'd3) + 1;
		for (int j = 0; j < reps; j++)
			send_key(idx, r[0]);
	end
	finish_test(5);

	run_done = 1'b1;
	tick();
	run_done = 1'b0;
	tick();
	if (errors == 0)
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

endmodule

//--- ps2_keyboard.f
logic/ps2_keyboard_pkg.sv
logic/ps2_receiver.sv
logic/scancode_map.sv
logic/key_event_filter.sv
logic/key_controller.sv
logic/ps2_keyboard.sv
verification/ps2_keyboard_checker.sv
verification/ps2_keyboard_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PS/2 keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ps2_keyboard_tb \
	-f ps2_keyboard.f -o ps2_keyboard_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/ps2_keyboard_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
